//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int BLOCK_BITS   = 64;
    localparam int OFFSET_BITS  = 3;
    localparam int N_LINES      = 32;
    localparam int INDEX_BITS   = 5;
    localparam int TAG_BITS     = 24;
    localparam int N_VICTIM     = 4;
    localparam int N_MSHR       = 4;
    localparam int MEM_TAG_BITS = 4;   // tag zero means nothing

    typedef logic [BLOCK_BITS-1:0] block_t;
    typedef logic [ADDR_WIDTH-OFFSET_BITS-1:0] line_addr_t;

    typedef enum logic [1:0] {BYTE, HALF, WORD} access_size_t;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} mem_command_t;

    // block address, used by the victim cache and the miss table
    function automatic line_addr_t line_of(input logic [ADDR_WIDTH-1:0] addr);
        return addr[ADDR_WIDTH-1:OFFSET_BITS];
    endfunction

    function automatic logic [INDEX_BITS-1:0] index_of(input logic [ADDR_WIDTH-1:0] addr);
        return addr[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
    endfunction

    function automatic logic [TAG_BITS-1:0] tag_of(input logic [ADDR_WIDTH-1:0] addr);
        return addr[ADDR_WIDTH-1:OFFSET_BITS+INDEX_BITS];
    endfunction

    // place store data into a block by size and byte offset
    function automatic block_t merge_store(input block_t blk,
                                           input logic [OFFSET_BITS-1:0] offset,
                                           input access_size_t size,
                                           input logic [31:0] wdata);
        block_t result;
        result = blk;
        case (size)
            BYTE:    result[{offset, 3'b000} +: 8] = wdata[7:0];
            HALF:    result[{offset[2:1], 4'b0000} +: 16] = wdata[15:0];
            default: result[{offset[2], 5'b00000} +: 32] = wdata;
        endcase
        return result;
    endfunction

endpackage

`default_nettype wire

//--- main_cache/main_cache_array.sv
`default_nettype none

module main_cache_array (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              lookup_en,
    input  wire logic                              req_store,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  dcache_pkg::access_size_t               req_size,
    input  wire logic [31:0]                       req_wdata,
    input  wire logic                              fill_valid,
    input  dcache_pkg::block_t                     fill_block,
    output logic                                   hit,
    output dcache_pkg::block_t                     hit_block,
    output logic                                   evict_valid,
    output logic                                   evict_dirty,
    output dcache_pkg::line_addr_t                 evict_line,
    output dcache_pkg::block_t                     evict_block
);
    import dcache_pkg::*;

    logic [N_LINES-1:0]  line_valid;
    logic [N_LINES-1:0]  line_dirty;
    logic [TAG_BITS-1:0] line_tag [N_LINES];
    block_t              line_data [N_LINES];

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    block_t                base_block;
    block_t                merged;
    logic                  store_hit;

    assign idx = index_of(req_addr);
    assign tag = tag_of(req_addr);

    assign hit       = lookup_en && line_valid[idx] && (line_tag[idx] == tag);
    assign hit_block = line_data[idx];
    assign store_hit = hit && req_store;

    // a store miss merges into the incoming block
    assign base_block = fill_valid ? fill_block : line_data[idx];
    assign merged     = merge_store(base_block, req_addr[OFFSET_BITS-1:0], req_size, req_wdata);

    // old line leaves in the fill cycle
    assign evict_valid = fill_valid && line_valid[idx];
    assign evict_dirty = line_dirty[idx];
    assign evict_line  = {line_tag[idx], idx};
    assign evict_block = line_data[idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (fill_valid) begin
            line_valid[idx] <= 1'b1;
            line_dirty[idx] <= req_store;
        end else if (store_hit) begin
            line_dirty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid || store_hit) begin
            line_data[idx] <= req_store ? merged : fill_block;
        end
        if (fill_valid) begin
            line_tag[idx] <= tag;
        end
    end

endmodule

`default_nettype wire

//--- victim_cache/victim_cache.sv
`default_nettype none

module victim_cache (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              lookup_en,
    input  wire logic                              req_store,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  dcache_pkg::access_size_t               req_size,
    input  wire logic [31:0]                       req_wdata,
    input  wire logic                              evict_valid,
    input  wire logic                              evict_dirty,
    input  dcache_pkg::line_addr_t                 evict_line,
    input  dcache_pkg::block_t                     evict_block,
    output logic                                   hit,
    output dcache_pkg::block_t                     hit_block,
    output logic                                   wb_valid,
    output dcache_pkg::line_addr_t                 wb_line,
    output dcache_pkg::block_t                     wb_block
);
    import dcache_pkg::*;

    logic [N_VICTIM-1:0]         entry_valid;
    logic [N_VICTIM-1:0]         entry_dirty;
    logic [$clog2(N_VICTIM)-1:0] entry_lru [N_VICTIM];   // highest is most recent
    line_addr_t                  entry_line [N_VICTIM];
    block_t                      entry_data [N_VICTIM];

    int                          hit_idx;
    int                          ins_idx;
    logic [$clog2(N_VICTIM)-1:0] best_lru;

    // full block address match across all entries
    always_comb begin
        hit     = 1'b0;
        hit_idx = 0;
        for (int i = 0; i < N_VICTIM; i++) begin
            if (lookup_en && entry_valid[i] && entry_line[i] == line_of(req_addr)) begin
                hit     = 1'b1;
                hit_idx = i;
            end
        end
    end

    assign hit_block = entry_data[hit_idx];

    // free entry first, else lowest count with lowest index
    always_comb begin
        ins_idx  = 0;
        best_lru = entry_lru[0];
        for (int i = 1; i < N_VICTIM; i++) begin
            if (entry_lru[i] < best_lru) begin
                ins_idx  = i;
                best_lru = entry_lru[i];
            end
        end
        for (int i = N_VICTIM - 1; i >= 0; i--) begin
            if (!entry_valid[i]) ins_idx = i;
        end
    end

    assign wb_valid = evict_valid && (&entry_valid) && entry_dirty[ins_idx];
    assign wb_line  = entry_line[ins_idx];
    assign wb_block = entry_data[ins_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_dirty <= '0;
            for (int i = 0; i < N_VICTIM; i++) begin
                entry_lru[i] <= '0;
            end
        end else begin
            if (hit) begin
                for (int i = 0; i < N_VICTIM; i++) begin
                    if (i == hit_idx) entry_lru[i] <= '1;
                    else if (entry_lru[i] != '0) entry_lru[i] <= entry_lru[i] - 1'b1;
                end
                if (req_store) entry_dirty[hit_idx] <= 1'b1;
            end
            if (evict_valid) begin
                entry_valid[ins_idx] <= 1'b1;
                entry_dirty[ins_idx] <= evict_dirty;
                entry_lru[ins_idx]   <= '0;   // new entries start oldest
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hit && req_store) begin
            entry_data[hit_idx] <= merge_store(entry_data[hit_idx], req_addr[OFFSET_BITS-1:0],
                                               req_size, req_wdata);
        end
        if (evict_valid) begin
            entry_line[ins_idx] <= evict_line;
            entry_data[ins_idx] <= evict_block;
        end
    end

endmodule

`default_nettype wire

//--- miss_table/miss_table.sv
`default_nettype none

module miss_table (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              refill_request,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  wire logic                              wb_valid,
    input  dcache_pkg::line_addr_t                 wb_line,
    input  dcache_pkg::block_t                     wb_block,
    input  wire logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input  dcache_pkg::block_t                     mem_rdata,
    input  wire logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_tag,
    output logic                                   entry_free,
    output logic                                   fill_valid,
    output dcache_pkg::block_t                     fill_block,
    output dcache_pkg::mem_command_t               mem_command,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]      mem_addr,
    output dcache_pkg::block_t                     mem_wdata
);
    import dcache_pkg::*;

    logic [N_MSHR-1:0]       entry_valid;
    logic [N_MSHR-1:0]       entry_store;    // write-back, else refill load
    logic [N_MSHR-1:0]       entry_issued;
    logic [MEM_TAG_BITS-1:0] entry_tag [N_MSHR];
    line_addr_t              entry_line [N_MSHR];
    block_t                  entry_data [N_MSHR];

    logic issue_any;
    logic accepted;
    int   issue_idx;
    int   fill_idx;
    int   alloc_idx;

    assign entry_free = !(&entry_valid);

    // stores go first so memory sees write-backs before refills
    always_comb begin
        issue_any = 1'b0;
        issue_idx = 0;
        for (int i = N_MSHR - 1; i >= 0; i--) begin
            if (entry_valid[i] && !entry_issued[i] && !entry_store[i]) begin
                issue_any = 1'b1;
                issue_idx = i;
            end
        end
        for (int i = N_MSHR - 1; i >= 0; i--) begin
            if (entry_valid[i] && !entry_issued[i] && entry_store[i]) begin
                issue_any = 1'b1;
                issue_idx = i;
            end
        end
    end

    always_comb begin
        fill_valid = 1'b0;
        fill_idx   = 0;
        for (int i = 0; i < N_MSHR; i++) begin
            if (mem_tag != '0 && entry_valid[i] && entry_issued[i] && !entry_store[i]
                && entry_tag[i] == mem_tag) begin
                fill_valid = 1'b1;
                fill_idx   = i;
            end
        end
    end

    // an entry freed by the fill can take the write-back of the same cycle
    always_comb begin
        alloc_idx = 0;
        for (int i = N_MSHR - 1; i >= 0; i--) begin
            if (!entry_valid[i] || (fill_valid && fill_idx == i)) alloc_idx = i;
        end
    end

    assign fill_block  = mem_rdata;
    assign accepted    = issue_any && (mem_response != '0);
    assign mem_command = !issue_any ? BUS_NONE : (entry_store[issue_idx] ? BUS_STORE : BUS_LOAD);
    assign mem_addr    = {entry_line[issue_idx], {OFFSET_BITS{1'b0}}};
    assign mem_wdata   = entry_store[issue_idx] ? entry_data[issue_idx] : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid  <= '0;
            entry_store  <= '0;
            entry_issued <= '0;
        end else begin
            if (fill_valid) entry_valid[fill_idx] <= 1'b0;
            if (accepted) begin
                if (entry_store[issue_idx]) entry_valid[issue_idx] <= 1'b0;   // store done
                else entry_issued[issue_idx] <= 1'b1;
            end
            if (refill_request || wb_valid) begin
                entry_valid[alloc_idx]  <= 1'b1;
                entry_store[alloc_idx]  <= wb_valid;
                entry_issued[alloc_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accepted && !entry_store[issue_idx]) entry_tag[issue_idx] <= mem_response;
        if (refill_request || wb_valid) begin
            entry_line[alloc_idx] <= wb_valid ? wb_line : line_of(req_addr);
            entry_data[alloc_idx] <= wb_block;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_control.sv
`default_nettype none

module dcache_control (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              req_valid,
    input  wire logic                              req_store,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  dcache_pkg::access_size_t               req_size,
    input  wire logic                              main_hit,
    input  dcache_pkg::block_t                     main_hit_block,
    input  wire logic                              victim_hit,
    input  dcache_pkg::block_t                     victim_hit_block,
    input  wire logic                              entry_free,
    input  wire logic                              fill_valid,
    input  dcache_pkg::block_t                     fill_block,
    output logic                                   stall,
    output logic                                   lookup_en,
    output logic                                   refill_request,
    output logic                                   resp_valid,
    output logic [31:0]                            resp_data
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {READY, WAIT_MSHR, WAIT} state_t;

    state_t   state, next_state;
    logic     retire_pending;   // filled request is still held by the pipeline
    logic     miss;
    logic     respond;
    block_t   src_block;
    logic [2:0]  off;
    logic [31:0] load_value;

    assign lookup_en = (state == READY) && req_valid && !retire_pending;
    assign miss      = lookup_en && !main_hit && !victim_hit;
    assign stall     = (state != READY) || miss;
    assign respond   = (lookup_en && !miss) || (state == WAIT && fill_valid);
    assign refill_request = entry_free && (miss || state == WAIT_MSHR);

    always_comb begin
        next_state = state;
        case (state)
            READY:     if (miss) next_state = entry_free ? WAIT : WAIT_MSHR;
            WAIT_MSHR: if (entry_free) next_state = WAIT;
            default:   if (fill_valid) next_state = READY;
        endcase
    end

    // sized load value at the request offset, zero extended
    always_comb begin
        src_block = main_hit ? main_hit_block : (victim_hit ? victim_hit_block : fill_block);
        off = req_addr[OFFSET_BITS-1:0];
        case (req_size)
            BYTE:    load_value = {24'b0, src_block[{off, 3'b000} +: 8]};
            HALF:    load_value = {16'b0, src_block[{off[2:1], 4'b0000} +: 16]};
            default: load_value = src_block[{off[2], 5'b00000} +: 32];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= READY;
            retire_pending <= 1'b0;
            resp_valid     <= 1'b0;
        end else begin
            state          <= next_state;
            retire_pending <= (state == WAIT) && fill_valid;
            resp_valid     <= respond;
        end
    end

    always_ff @(posedge clock) begin
        resp_data <= req_store ? 32'b0 : load_value;   // stores answer with zero
    end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`default_nettype none

module dcache_top (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              req_valid,
    input  wire logic                              req_store,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  dcache_pkg::access_size_t               req_size,
    input  wire logic [31:0]                       req_wdata,
    output logic                                   stall,
    output logic                                   resp_valid,
    output logic [31:0]                            resp_data,
    output dcache_pkg::mem_command_t               mem_command,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]      mem_addr,
    output dcache_pkg::block_t                     mem_wdata,
    input  wire logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_response,
    input  dcache_pkg::block_t                     mem_rdata,
    input  wire logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_tag
);
    import dcache_pkg::*;

    logic       lookup_en;
    logic       refill_request;
    logic       main_hit;
    block_t     main_hit_block;
    logic       victim_hit;
    block_t     victim_hit_block;
    logic       entry_free;
    logic       fill_valid;
    block_t     fill_block;
    logic       evict_valid;
    logic       evict_dirty;
    line_addr_t evict_line;
    block_t     evict_block;
    logic       wb_valid;
    line_addr_t wb_line;
    block_t     wb_block;

    dcache_control control (
        .clock, .reset, .req_valid, .req_store, .req_addr, .req_size,
        .main_hit, .main_hit_block, .victim_hit, .victim_hit_block,
        .entry_free, .fill_valid, .fill_block,
        .stall, .lookup_en, .refill_request, .resp_valid, .resp_data
    );

    main_cache_array main_cache (
        .clock, .reset, .lookup_en, .req_store, .req_addr, .req_size, .req_wdata,
        .fill_valid, .fill_block,
        .hit(main_hit), .hit_block(main_hit_block),
        .evict_valid, .evict_dirty, .evict_line, .evict_block
    );

    victim_cache victim (
        .clock, .reset, .lookup_en, .req_store, .req_addr, .req_size, .req_wdata,
        .evict_valid, .evict_dirty, .evict_line, .evict_block,
        .hit(victim_hit), .hit_block(victim_hit_block),
        .wb_valid, .wb_line, .wb_block
    );

    miss_table mshr (
        .clock, .reset, .refill_request, .req_addr, .wb_valid, .wb_line, .wb_block,
        .mem_response, .mem_rdata, .mem_tag,
        .entry_free, .fill_valid, .fill_block, .mem_command, .mem_addr, .mem_wdata
    );

endmodule

`default_nettype wire

//--- bench/dcache_assertions.sv
`default_nettype none

module dcache_assertions (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              req_valid,
    input  wire logic                              req_store,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] req_addr,
    input  dcache_pkg::access_size_t               req_size,
    input  wire logic [31:0]                       req_wdata,
    input  wire logic                              stall,
    input  wire logic                              resp_valid,
    input  dcache_pkg::mem_command_t               mem_command,
    input  wire logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr
);
    timeunit 1ns;
    timeprecision 1ns;
    import dcache_pkg::*;

    int fail_count = 0;   // failed assertions so far

    quiet_in_reset: assert property (@(posedge clock) reset |=> mem_command == BUS_NONE)
        else begin
            $error("memory command issued during reset");
            fail_count++;
        end

    // a request that retires in its first cycle, after a cycle without stall, is a hit
    hit_response: assert property (@(posedge clock) disable iff (reset)
        (req_valid && !stall && !$past(stall)) |=> resp_valid)
        else begin
            $error("no response one cycle after a retired hit");
            fail_count++;
        end

    request_held: assert property (@(posedge clock) disable iff (reset)
        (req_valid && stall) |=> (req_valid && $stable(req_store) && $stable(req_addr)
                                  && $stable(req_size) && $stable(req_wdata)))
        else begin
            $error("request changed while stall was high");
            fail_count++;
        end

    store_aligned: assert property (@(posedge clock) disable iff (reset)
        (mem_command == BUS_STORE) |-> (mem_addr[OFFSET_BITS-1:0] == '0))
        else begin
            $error("write-back address not block aligned");
            fail_count++;
        end

endmodule

bind dcache_top dcache_assertions checks (.*);

`default_nettype wire

//--- bench/dcache_tb.sv
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import dcache_pkg::*;

    localparam int MEM_BYTES      = 8192;   // byte addresses wrap at 13 bits
    localparam int ACCESS_TIMEOUT = 200;    // cycles for one request

    logic                    clock;
    logic                    reset;
    logic                    req_valid;
    logic                    req_store;
    logic [31:0]             req_addr;
    access_size_t            req_size;
    logic [31:0]             req_wdata;
    logic                    stall;
    logic                    resp_valid;
    logic [31:0]             resp_data;
    mem_command_t            mem_command;
    logic [31:0]             mem_addr;
    block_t                  mem_wdata;
    logic [MEM_TAG_BITS-1:0] mem_response;
    block_t                  mem_rdata;
    logic [MEM_TAG_BITS-1:0] mem_tag;

    logic [7:0]  shadow_mem [MEM_BYTES];   // memory behind the cache
    logic [7:0]  ref_mem [MEM_BYTES];      // what the pipeline should read back
    logic [31:0] lfsr;
    logic        refusals_on;
    logic        late_resp;                // last response came after the retiring edge
    int          checks;
    int          errors;
    int          cycle;
    int          cmd_cycles;
    int          n_stores;
    logic [MEM_TAG_BITS-1:0] pend_tag [$];
    block_t      pend_data [$];
    int          pend_due [$];

    dcache_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic block_t block_from(input logic [31:0] addr, input logic use_ref);
        block_t      blk;
        logic [12:0] base;
        base = {addr[12:3], 3'b000};
        for (int i = 0; i < 8; i++) begin
            blk[8*i +: 8] = use_ref ? ref_mem[base + i] : shadow_mem[base + i];
        end
        return blk;
    endfunction

    // little endian, zero extended
    function automatic logic [31:0] expected_load(input logic [31:0] addr, input access_size_t size);
        logic [12:0] a;
        a = addr[12:0];
        case (size)
            BYTE:    return {24'b0, ref_mem[a]};
            HALF:    return {16'b0, ref_mem[a + 1], ref_mem[a]};
            default: return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
        endcase
    endfunction

    task automatic update_ref(input logic [31:0] addr, input access_size_t size,
                              input logic [31:0] wdata);
        int n;
        n = (size == BYTE) ? 1 : ((size == HALF) ? 2 : 4);
        for (int i = 0; i < n; i++) ref_mem[addr[12:0] + i] = wdata[8*i +: 8];
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t: %s did not finish", $time, what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // one request under the pipeline handshake, checked against the reference copy
    task automatic access(input logic store, input logic [31:0] addr,
                          input access_size_t size, input logic [31:0] wdata);
        logic [31:0] expected;
        logic [31:0] got;
        int          n_resp;
        int          waited;
        expected  = store ? 32'b0 : expected_load(addr, size);
        got       = '0;
        n_resp    = 0;
        waited    = 0;
        late_resp = 1'b0;
        @(posedge clock);
        #5;
        req_valid = 1'b1;
        req_store = store;
        req_addr  = addr;
        req_size  = size;
        req_wdata = wdata;
        do begin
            @(negedge clock);
            if (resp_valid) begin
                n_resp++;
                got = resp_data;
            end
            waited++;
            if (waited > ACCESS_TIMEOUT) stop_on_timeout("cache request");
        end while (stall);
        @(posedge clock);   // retiring edge
        if (store) update_ref(addr, size, wdata);
        #5;
        req_valid = 1'b0;
        @(negedge clock);
        if (resp_valid) begin
            n_resp++;
            got       = resp_data;
            late_resp = 1'b1;
        end
        check_value("response count", n_resp, 1);
        check_value("resp_data", got, expected);
    endtask

    // memory model, results come back in acceptance order
    initial begin
        logic [31:0]             bits;
        logic [MEM_TAG_BITS-1:0] next_tag;
        int                      due;
        int                      last_due;
        next_tag = 1;
        last_due = 0;
        forever begin
            @(posedge clock);
            #5;
            mem_tag      = '0;
            mem_response = '0;
            cycle++;
            if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                mem_tag   = pend_tag.pop_front();
                mem_rdata = pend_data.pop_front();
                void'(pend_due.pop_front());
            end
            if (!reset && mem_command != BUS_NONE) begin
                cmd_cycles++;
                bits = 32'd1;
                if (refusals_on) take_bits(1, bits);
                if (bits[0]) begin
                    mem_response = next_tag;
                    if (mem_command == BUS_STORE) begin
                        check_value("mem_wdata", mem_wdata, block_from(mem_addr, 1'b1));
                        for (int i = 0; i < 8; i++) begin
                            shadow_mem[{mem_addr[12:3], 3'b000} + i] = mem_wdata[8*i +: 8];
                        end
                        n_stores++;
                    end else begin
                        take_bits(2, bits);
                        due = cycle + 1 + int'(bits[1:0]);   // 1 to 4 cycles
                        if (due <= last_due) due = last_due + 1;
                        last_due = due;
                        pend_tag.push_back(next_tag);
                        pend_data.push_back(block_from(mem_addr, 1'b0));
                        pend_due.push_back(due);
                    end
                    next_tag = (next_tag == '1) ? 1 : next_tag + 1'b1;
                end
            end
        end
    end

    initial begin
        int           e0;
        int           cmd0;
        int           stores0;
        logic [31:0]  r;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        access_size_t size;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_store    = 1'b0;
        req_addr     = '0;
        req_size     = WORD;
        req_wdata    = '0;
        mem_response = '0;
        mem_rdata    = '0;
        mem_tag      = '0;
        lfsr         = 32'h6bb6_da14;
        refusals_on  = 1'b0;
        checks       = 0;
        errors       = 0;
        cycle        = 0;
        cmd_cycles   = 0;
        n_stores     = 0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            shadow_mem[a] = 8'(a * 7);
            ref_mem[a]    = 8'(a * 7);
        end
        repeat (10) @(posedge clock);
        #5;
        reset = 1'b0;

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_value("stall", stall, 0);
            check_value("resp_valid", resp_valid, 0);
            check_value("mem_command", mem_command, BUS_NONE);
        end
        report_test("idle after reset", e0);

        e0 = errors;
        access(1'b0, 32'h100, WORD, '0);
        cmd0 = cmd_cycles;
        access(1'b0, 32'h106, HALF, '0);
        check_value("late_resp", late_resp, 1);
        check_value("memory command cycles", cmd_cycles - cmd0, 0);
        report_test("load miss then hit", e0);

        e0 = errors;
        access(1'b1, 32'h109, BYTE, 32'h0000_00a5);
        access(1'b1, 32'h10e, HALF, 32'h0000_beef);
        access(1'b1, 32'h110, WORD, 32'h1234_5678);   // store miss
        access(1'b1, 32'h117, BYTE, 32'h0000_003c);
        access(1'b0, 32'h108, WORD, '0);
        access(1'b0, 32'h10c, WORD, '0);
        access(1'b0, 32'h10e, HALF, '0);
        access(1'b0, 32'h109, BYTE, '0);
        access(1'b0, 32'h110, WORD, '0);
        access(1'b0, 32'h114, WORD, '0);
        report_test("sized stores and loads", e0);

        e0 = errors;
        access(1'b1, 32'h11c, WORD, 32'hcafe_f00d);
        access(1'b0, 32'h218, WORD, '0);   // same index, pushes 0x118 out
        cmd0 = cmd_cycles;
        access(1'b0, 32'h11c, WORD, '0);
        check_value("late_resp", late_resp, 1);
        check_value("memory command cycles", cmd_cycles - cmd0, 0);
        access(1'b0, 32'h11d, BYTE, '0);
        access(1'b0, 32'h118, HALF, '0);
        report_test("victim hit", e0);

        e0 = errors;
        stores0 = n_stores;
        for (int t = 1; t <= 7; t++) access(1'b1, t * 256 + 32'h2c, WORD, t * 32'h1111_1111);
        for (int t = 1; t <= 7; t++) begin
            access(1'b0, t * 256 + 32'h28, WORD, '0);
            access(1'b0, t * 256 + 32'h2c, WORD, '0);
        end
        check_value("write-backs seen", n_stores > stores0, 1);
        report_test("dirty write-backs", e0);

        e0 = errors;
        refusals_on = 1'b1;
        for (int i = 0; i < 40; i++) begin
            take_bits(11, r);
            size = (r[1:0] == 2'd0) ? BYTE : ((r[1:0] == 2'd1) ? HALF : WORD);
            addr = ((32'(r[4:2]) + 1) << 8) | (32'(r[6:5]) << 3) | 32'(r[9:7]);
            if (size != BYTE) addr[0] = 1'b0;
            if (size == WORD) addr[1] = 1'b0;
            take_bits(32, wdata);
            access(r[10], addr, size, wdata);
        end
        refusals_on = 1'b0;
        report_test("random with refusals", e0);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.checks.fail_count);
        if (errors == 0 && DUT.checks.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/dcache_pkg.sv
main_cache/main_cache_array.sv
victim_cache/victim_cache.sv
miss_table/miss_table.sv
hdl/dcache_control.sv
hdl/dcache_top.sv
bench/dcache_assertions.sv
bench/dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the data cache and its testbench with Verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module dcache_tb -f sources.f -o dcache_sim

./obj_dir/dcache_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation run ok"
else
    echo "simulation run reported failure"
    exit 1
fi
